/* source/execCore_defs.svh */
`ifndef EXECCORE_DEFS_SVH
`define EXECCORE_DEFS_SVH

// Architectural register count.
`define REG_COUNT 16

// Datapath width in bits.
`define DATA_WIDTH 32

// Data memory size in words.
`define DMEM_WORDS 64

`endif

/* source/execCorePkg.sv */
`include "execCore_defs.svh"

package execCorePkg;

	localparam int regBits = $clog2(`REG_COUNT);

	// ARM data-processing encodings, pass-B in a spare slot.
	typedef enum logic [3:0] {
		aluAnd   = 4'b0000,
		aluEor   = 4'b0001,
		aluSub   = 4'b0010,
		aluAdd   = 4'b0100,
		aluOrr   = 4'b1100,
		aluMov   = 4'b1101,
		aluPassB = 4'b1110,
		aluMvn   = 4'b1111
	} aluOpT;

	typedef enum logic [3:0] {
		condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
		condHi, condLs, condGe, condLt, condGt, condLe, condAl
	} condT;

	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdMem = 2'b01,
		fwdWb  = 2'b10
	} fwdSelT;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	typedef struct packed {
		logic [regBits-1:0] ra;
		logic [regBits-1:0] rb;
		logic [regBits-1:0] rd;
		logic [`DATA_WIDTH-1:0] imm;
		aluOpT aluOp;
		condT cond;
		logic useImm;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic flagWrite;
		logic branch;
	} issueT;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [regBits-1:0] ra;
		logic [regBits-1:0] rb;
		logic [regBits-1:0] rd;
		logic [`DATA_WIDTH-1:0] imm;
		aluOpT aluOp;
		condT cond;
		logic useImm;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic flagWrite;
		logic branch;
	} exeT;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] result;
		logic [`DATA_WIDTH-1:0] storeData;
		logic [regBits-1:0] rd;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic branch;
	} memT;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] value;
		logic [regBits-1:0] rd;
		logic regWrite;
	} wbT;

endpackage

/* source/regReadStage.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module regReadStage (
	input  logic                Clk,
	input  logic                rstN,
	input  logic                issueValid,
	input  execCorePkg::issueT  issue,
	input  execCorePkg::wbT     wb,
	input  logic                wbValid,
	output logic                exeValid,
	output execCorePkg::exeT    exe
);

	logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
	logic wrEn;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;

	assign wrEn = wbValid && wb.regWrite;

	// Same-cycle writeback is visible to the read.
	assign opA = (wrEn && wb.rd == issue.ra) ? wb.value : regFile[issue.ra];
	assign opB = (wrEn && wb.rd == issue.rb) ? wb.value : regFile[issue.rb];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (wrEn) begin
			regFile[wb.rd] <= wb.value;
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			exeValid <= 1'b0;
		end else begin
			exeValid <= issueValid;
		end
	end

	always_ff @(posedge Clk) begin
		exe.a         <= opA;
		exe.b         <= opB;
		exe.ra        <= issue.ra;
		exe.rb        <= issue.rb;
		exe.rd        <= issue.rd;
		exe.imm       <= issue.imm;
		exe.aluOp     <= issue.aluOp;
		exe.cond      <= issue.cond;
		exe.useImm    <= issue.useImm;
		exe.regWrite  <= issue.regWrite;
		exe.memToReg  <= issue.memToReg;
		exe.memWrite  <= issue.memWrite;
		exe.flagWrite <= issue.flagWrite;
		exe.branch    <= issue.branch;
	end

endmodule

/* source/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit (
	input  logic [execCorePkg::regBits-1:0] srcA,
	input  logic [execCorePkg::regBits-1:0] srcB,
	input  logic                            exeValid,
	input  logic [execCorePkg::regBits-1:0] memRd,
	input  logic                            memRegWrite,
	input  logic                            memValid,
	input  logic [execCorePkg::regBits-1:0] wbRd,
	input  logic                            wbRegWrite,
	input  logic                            wbValid,
	output execCorePkg::fwdSelT             fwdA,
	output execCorePkg::fwdSelT             fwdB
);

	logic memLive;
	logic wbLive;

	assign memLive = exeValid && memValid && memRegWrite;
	assign wbLive  = exeValid && wbValid && wbRegWrite;

	// Youngest producer wins.
	assign fwdA = (memLive && memRd == srcA) ? execCorePkg::fwdMem :
		(wbLive && wbRd == srcA) ? execCorePkg::fwdWb : execCorePkg::fwdReg;
	assign fwdB = (memLive && memRd == srcB) ? execCorePkg::fwdMem :
		(wbLive && wbRd == srcB) ? execCorePkg::fwdWb : execCorePkg::fwdReg;

endmodule

/* source/alu.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] a,
	input  logic [`DATA_WIDTH-1:0] b,
	input  execCorePkg::aluOpT     op,
	output logic [`DATA_WIDTH-1:0] result,
	output execCorePkg::flagsT     aluFlags
);

	localparam int msb = `DATA_WIDTH - 1;

	logic [`DATA_WIDTH:0] sum;
	logic carry;
	logic overflow;

	always_comb begin
		sum      = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (op)
			execCorePkg::aluAdd: begin
				sum      = {1'b0, a} + {1'b0, b};
				result   = sum[msb:0];
				carry    = sum[`DATA_WIDTH];
				overflow = (a[msb] == b[msb]) && (result[msb] != a[msb]);
			end
			execCorePkg::aluSub: begin
				// Carry set means no borrow.
				sum      = {1'b0, a} + {1'b0, ~b} + 1'b1;
				result   = sum[msb:0];
				carry    = sum[`DATA_WIDTH];
				overflow = (a[msb] != b[msb]) && (result[msb] != a[msb]);
			end
			execCorePkg::aluAnd:   result = a & b;
			execCorePkg::aluOrr:   result = a | b;
			execCorePkg::aluEor:   result = a ^ b;
			execCorePkg::aluMov:   result = b;
			execCorePkg::aluMvn:   result = ~b;
			execCorePkg::aluPassB: result = b;
			default:               result = '0;
		endcase
	end

	assign aluFlags.n = result[msb];
	assign aluFlags.z = (result == '0);
	assign aluFlags.c = carry;
	assign aluFlags.v = overflow;

endmodule

/* source/condUnit.sv */
`timescale 1ns/1ps

module condUnit (
	input  logic               Clk,
	input  logic               rstN,
	input  execCorePkg::condT  cond,
	input  execCorePkg::flagsT aluFlags,
	input  logic               flagWrite,
	input  logic               valid,
	output logic               condPass,
	output execCorePkg::flagsT flags
);

	// Evaluated against flags from before this instruction.
	always_comb begin
		case (cond)
			execCorePkg::condEq: condPass = flags.z;
			execCorePkg::condNe: condPass = !flags.z;
			execCorePkg::condCs: condPass = flags.c;
			execCorePkg::condCc: condPass = !flags.c;
			execCorePkg::condMi: condPass = flags.n;
			execCorePkg::condPl: condPass = !flags.n;
			execCorePkg::condVs: condPass = flags.v;
			execCorePkg::condVc: condPass = !flags.v;
			execCorePkg::condHi: condPass = flags.c && !flags.z;
			execCorePkg::condLs: condPass = !flags.c || flags.z;
			execCorePkg::condGe: condPass = (flags.n == flags.v);
			execCorePkg::condLt: condPass = (flags.n != flags.v);
			execCorePkg::condGt: condPass = !flags.z && (flags.n == flags.v);
			execCorePkg::condLe: condPass = flags.z || (flags.n != flags.v);
			execCorePkg::condAl: condPass = 1'b1;
			default:             condPass = 1'b0;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (valid && condPass && flagWrite) begin
			flags <= aluFlags;
		end
	end

endmodule

/* source/executeStage.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module executeStage (
	input  logic               Clk,
	input  logic               rstN,
	input  logic               exeValid,
	input  execCorePkg::exeT   exe,
	input  execCorePkg::memT   memFwd,
	input  logic               memValid,
	input  execCorePkg::wbT    wbFwd,
	input  logic               wbValid,
	output logic               memOutValid,
	output execCorePkg::memT   memOut,
	output execCorePkg::flagsT flags
);

	execCorePkg::fwdSelT fwdA;
	execCorePkg::fwdSelT fwdB;
	execCorePkg::flagsT aluFlags;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] aluB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic condPass;

	forwardUnit fwd (
		.srcA(exe.ra),
		.srcB(exe.rb),
		.exeValid(exeValid),
		.memRd(memFwd.rd),
		.memRegWrite(memFwd.regWrite),
		.memValid(memValid),
		.wbRd(wbFwd.rd),
		.wbRegWrite(wbFwd.regWrite),
		.wbValid(wbValid),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	always_comb begin
		case (fwdA)
			execCorePkg::fwdMem: opA = memFwd.result;
			execCorePkg::fwdWb:  opA = wbFwd.value;
			default:             opA = exe.a;
		endcase
		case (fwdB)
			execCorePkg::fwdMem: opB = memFwd.result;
			execCorePkg::fwdWb:  opB = wbFwd.value;
			default:             opB = exe.b;
		endcase
	end

	assign aluB = exe.useImm ? exe.imm : opB;

	alu aluInst (
		.a(opA),
		.b(aluB),
		.op(exe.aluOp),
		.result(aluResult),
		.aluFlags(aluFlags)
	);

	condUnit cond (
		.Clk(Clk),
		.rstN(rstN),
		.cond(exe.cond),
		.aluFlags(aluFlags),
		.flagWrite(exe.flagWrite),
		.valid(exeValid),
		.condPass(condPass),
		.flags(flags)
	);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			memOutValid <= 1'b0;
		end else begin
			memOutValid <= exeValid;
		end
	end

	// A failed condition drops every side effect.
	always_ff @(posedge Clk) begin
		memOut.result    <= aluResult;
		memOut.storeData <= opB;
		memOut.rd        <= exe.rd;
		memOut.regWrite  <= exe.regWrite && condPass;
		memOut.memToReg  <= exe.memToReg;
		memOut.memWrite  <= exe.memWrite && condPass;
		memOut.branch    <= exe.branch && condPass;
	end

endmodule

/* source/memoryStage.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module memoryStage (
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   memValid,
	input  execCorePkg::memT       mem,
	output logic                   wbValid,
	output execCorePkg::wbT        wb,
	output logic                   branchTaken,
	output logic [`DATA_WIDTH-1:0] branchTarget
);

	localparam int addrBits = $clog2(`DMEM_WORDS);

	logic [`DATA_WIDTH-1:0] dmem [`DMEM_WORDS];
	logic [addrBits-1:0] wordAddr;
	logic [`DATA_WIDTH-1:0] readData;

	// Byte address, low two bits dropped.
	assign wordAddr = mem.result[addrBits+1:2];
	assign readData = dmem[wordAddr];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (memValid && mem.memWrite) begin
			dmem[wordAddr] <= mem.storeData;
		end
	end

	assign branchTaken  = memValid && mem.branch;
	assign branchTarget = mem.result;

	// Only retiring register writes reach writeback.
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= memValid && mem.regWrite;
		end
	end

	always_ff @(posedge Clk) begin
		wb.value    <= mem.memToReg ? readData : mem.result;
		wb.rd       <= mem.rd;
		wb.regWrite <= mem.regWrite;
	end

endmodule

/* source/execCore.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module execCore (
	input  logic                            Clk,
	input  logic                            rstN,
	input  logic                            issueValid,
	input  execCorePkg::issueT              issue,
	output logic                            wbValid,
	output logic [execCorePkg::regBits-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]          wbData,
	output logic                            branchTaken,
	output logic [`DATA_WIDTH-1:0]          branchTarget,
	output execCorePkg::flagsT              flags
);

	logic exeValid;
	execCorePkg::exeT exe;
	logic memValid;
	execCorePkg::memT mem;
	execCorePkg::wbT wb;

	regReadStage regRead (
		.Clk(Clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.issue(issue),
		.wb(wb),
		.wbValid(wbValid),
		.exeValid(exeValid),
		.exe(exe)
	);

	executeStage execute (
		.Clk(Clk),
		.rstN(rstN),
		.exeValid(exeValid),
		.exe(exe),
		.memFwd(mem),
		.memValid(memValid),
		.wbFwd(wb),
		.wbValid(wbValid),
		.memOutValid(memValid),
		.memOut(mem),
		.flags(flags)
	);

	memoryStage memory (
		.Clk(Clk),
		.rstN(rstN),
		.memValid(memValid),
		.mem(mem),
		.wbValid(wbValid),
		.wb(wb),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	assign wbReg  = wb.rd;
	assign wbData = wb.value;

endmodule

/* testbench/execCoreChecker.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module execCoreChecker (
	input  logic                            Clk,
	input  logic                            rstN,
	input  logic                            wbValid,
	input  logic [execCorePkg::regBits-1:0] wbReg,
	input  logic [`DATA_WIDTH-1:0]          wbData,
	input  logic                            branchTaken,
	input  logic [`DATA_WIDTH-1:0]          branchTarget,
	input  execCorePkg::flagsT              flags,
	output int                              errorCount,
	output int                              pendingCount,
	output int                              testsDone
);

	localparam int watchLimit = 100000;

	// Expected events in retire order.
	int expWbTest[$];
	logic [31:0] expWbReg[$];
	logic [31:0] expWbValue[$];
	logic [7:0] expWbFlags[$];
	int expBrTest[$];
	logic [31:0] expBrTarget[$];
	int pending[int];
	int testErrors[int];

	task automatic loadExpected;
		int fd;
		string line;
		int t;
		int kind;
		logic [31:0] r, v;
		logic [7:0] f;
		fd = $fopen("testbench/execCore_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open the tests file");
			errorCount++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "E %h %h %h %h %h", t, kind, r, v, f) == 5) begin
					if (kind == 0) begin
						expWbTest.push_back(t);
						expWbReg.push_back(r);
						expWbValue.push_back(v);
						expWbFlags.push_back(f);
					end else begin
						expBrTest.push_back(t);
						expBrTarget.push_back(v);
					end
					pending[t] = pending.exists(t) ? pending[t] + 1 : 1;
					testErrors[t] = 0;
					pendingCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic retire(input int t, input logic ok);
		if (!ok) begin
			errorCount++;
			testErrors[t]++;
		end
		pending[t]--;
		pendingCount--;
		if (pending[t] == 0) begin
			testsDone++;
			$display("test %0d finished, %0d mismatches", t, testErrors[t]);
		end
	endtask

	// Outputs settle well before the falling edge.
	initial begin
		int t;
		logic ok;
		logic [31:0] r, v;
		logic [7:0] f;
		errorCount = 0;
		pendingCount = 0;
		testsDone = 0;
		loadExpected();
		repeat (watchLimit) begin
			@(negedge Clk);
			if (rstN && wbValid) begin
				if (expWbTest.size() == 0) begin
					$display("unexpected writeback of r%0d at %0t", wbReg, $time);
					errorCount++;
				end else begin
					t = expWbTest.pop_front();
					r = expWbReg.pop_front();
					v = expWbValue.pop_front();
					f = expWbFlags.pop_front();
					// Flags value 10 means not checked.
					ok = (wbReg === r[execCorePkg::regBits-1:0]) && (wbData === v) &&
						(f == 8'h10 || flags === f[3:0]);
					if (!ok) begin
						$display("FAILED %0t test %0d: got r%0d=%h flags %h, want r%0d=%h flags %h",
							$time, t, wbReg, wbData, flags, r, v, f);
					end
					retire(t, ok);
				end
			end
			if (rstN && branchTaken) begin
				if (expBrTest.size() == 0) begin
					$display("unexpected branch to %h at %0t", branchTarget, $time);
					errorCount++;
				end else begin
					t = expBrTest.pop_front();
					v = expBrTarget.pop_front();
					ok = (branchTarget === v);
					if (!ok) begin
						$display("FAILED %0t test %0d: branch to %h, expected %h",
							$time, t, branchTarget, v);
					end
					retire(t, ok);
				end
			end
		end
	end

endmodule

/* testbench/execCoreTb.sv */
`timescale 1ns/1ps
`include "execCore_defs.svh"

module execCoreTb;

	localparam int waitLimit = 2000;

	logic Clk = 1'b0;
	logic rstN;
	logic issueValid;
	execCorePkg::issueT issue;
	logic wbValid;
	logic [execCorePkg::regBits-1:0] wbReg;
	logic [`DATA_WIDTH-1:0] wbData;
	logic branchTaken;
	logic [`DATA_WIDTH-1:0] branchTarget;
	execCorePkg::flagsT flags;
	int errorCount;
	int pendingCount;
	int testsDone;
	execCorePkg::issueT instQ[$];
	logic [31:0] lfsr = 32'h676d;

	always #10 Clk = ~Clk;

	execCore dut (.*);

	execCoreChecker scoreboard (.*);

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic loadProgram(output int loadErrors);
		int fd;
		string line;
		int t;
		logic [31:0] ra, rb, rd, imm, op, cond;
		logic [5:0] ctl;
		execCorePkg::issueT ins;
		loadErrors = 0;
		fd = $fopen("testbench/execCore_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open the tests file");
			loadErrors = 1;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "I %h %h %h %h %h %h %h %b",
						t, ra, rb, rd, imm, op, cond, ctl) == 8) begin
					ins = '0;
					ins.ra = ra[execCorePkg::regBits-1:0];
					ins.rb = rb[execCorePkg::regBits-1:0];
					ins.rd = rd[execCorePkg::regBits-1:0];
					ins.imm = imm;
					ins.aluOp = execCorePkg::aluOpT'(op[3:0]);
					ins.cond = execCorePkg::condT'(cond[3:0]);
					{ins.useImm, ins.regWrite, ins.memToReg,
						ins.memWrite, ins.flagWrite, ins.branch} = ctl;
					instQ.push_back(ins);
				end
			end
			$fclose(fd);
		end
	endtask

	// Idle gap of 0 to 3 slots after each instruction.
	task automatic issueAll;
		int gap;
		foreach (instQ[i]) begin
			@(negedge Clk);
			issueValid = 1'b1;
			issue = instQ[i];
			gap = 0;
			// First bit taken is the low bit of the gap.
			repeat (2) begin
				gap = (gap >> 1) | (lfsr[0] ? 2 : 0);
				lfsr = lfsrNext(lfsr);
			end
			repeat (gap) begin
				@(negedge Clk);
				issueValid = 1'b0;
			end
		end
		@(negedge Clk);
		issueValid = 1'b0;
	endtask

	initial begin
		int loadErrors;
		int waited;
		logic timedOut;
		rstN = 1'b0;
		issueValid = 1'b0;
		issue = '0;
		loadProgram(loadErrors);
		repeat (10) @(negedge Clk);
		rstN = 1'b1;
		issueAll();
		waited = 0;
		while (pendingCount != 0 && waited < waitLimit) begin
			@(negedge Clk);
			waited++;
		end
		timedOut = (pendingCount != 0);
		if (timedOut) begin
			$display("timeout: %0d expected events never arrived", pendingCount);
		end
		// Room for a stray strobe to show up.
		repeat (6) @(negedge Clk);
		$display("%0d tests finished, %0d errors, %0d events pending",
			testsDone, errorCount, pendingCount);
		if (errorCount == 0 && loadErrors == 0 && !timedOut) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* testbench/execCore_tests.txt */
# I test ra rb rd imm aluOp cond ctl (useImm regWrite memToReg memWrite flagWrite branch)
# E test kind (0 writeback, 1 branch) reg value flags (10 = not checked)
I 1 0 0 1 5 d e 110000
I 1 1 0 2 3 0 e 110000
I 1 1 0 3 3 c e 110000
I 1 1 0 4 3 1 e 110000
I 1 1 3 5 0 2 e 010000
I 1 0 1 6 0 f e 010000
E 1 0 1 5 10
E 1 0 2 1 10
E 1 0 3 7 10
E 1 0 4 6 10
E 1 0 5 fffffffe 10
E 1 0 6 fffffffa 10
I 2 1 0 9 1 4 e 110000
I 2 9 0 a 1 4 e 110000
I 2 9 a b 0 4 e 010000
E 2 0 9 6 10
E 2 0 a 7 10
E 2 0 b d 10
I 3 1 0 c 5 2 e 110010
I 3 0 0 d 1 d 0 110000
I 3 0 0 d 2 d 1 110000
I 3 0 0 d 3 d a 110000
I 3 0 0 d 4 d b 110000
E 3 0 c 0 6
E 3 0 d 1 6
E 3 0 d 3 6
I 4 0 6 0 8 4 e 100100
I 4 0 4 0 8 4 1 100100
I 4 0 0 3 8 4 e 111000
E 4 0 3 fffffffa 10
I 5 0 0 0 100 e e 100001
I 5 1 0 0 6 2 e 100010
I 5 0 0 0 200 e b 100001
I 5 0 0 0 300 e a 100001
E 5 1 0 100 10
E 5 1 0 200 10
I 6 0 f e 0 d e 010000
E 6 0 e 0 10

/* build.f */
+incdir+source
source/execCorePkg.sv
source/regReadStage.sv
source/forwardUnit.sv
source/alu.sv
source/condUnit.sv
source/executeStage.sv
source/memoryStage.sv
source/execCore.sv
testbench/execCoreChecker.sv
testbench/execCoreTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module execCoreTb -o execCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
./obj_dir/execCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "^Test passed$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
